// File: build.f
common/slurm16_mem_pkg.sv
rtl/slurm16_word_ram.sv
rtl/slurm16_memory_arbiter.sv
rtl/slurm16_cpu_memory_interface.sv
rtl/slurm16_memory_subsystem.sv
sim/tb_slurm16_memory_subsystem.sv

// File: Makefile
# Verilator build and run of the slurm16 memory subsystem testbench

VERILATOR := verilator
TOP       := tb_slurm16_memory_subsystem
FILELIST  := build.f
FLAGS     := --binary --timing --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ** PASS **
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_slurm16_memory_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the slurm16 memory subsystem
// Reference word model, one task per behavior and a value check task
// Covers reset, data and byte-lane writes, pipelined fetches,
// data over fetch priority and auxiliary port collisions
////////////////////////////////////////////////////////////////////////////

module tb_slurm16_memory_subsystem;

	timeunit 1ns;
	timeprecision 100ps;

	import slurm16_mem_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int RESULT_LATENCY = 2; // Request edge to result, in cycles
	localparam int FETCHES = 4;

	logic CLK = 1'b0;
	logic RSTb;
	logic [ADDRESS_BITS-1:0] instruction_memory_address;
	logic instruction_memory_read_req;
	logic [BITS-1:0] instruction_memory_data;
	logic [ADDRESS_BITS-1:0] instruction_memory_address_out;
	logic instruction_memory_success;
	cpu_data_req_t data_req;
	logic [BITS-1:0] data_memory_rdata;
	logic data_memory_success;
	byte_mask_t data_memory_wr_mask_out;
	logic [ADDRESS_BITS-1:0] aux_address;
	logic aux_rd;
	logic [BITS-1:0] aux_rdata;
	logic aux_rdata_valid;

	logic [BITS-1:0] ref_mem [RAM_WORDS]; // Only written words are ever compared

	slurm16_memory_subsystem UUT (
		.CLK(CLK),
		.RSTb(RSTb),
		.instruction_memory_address(instruction_memory_address),
		.instruction_memory_read_req(instruction_memory_read_req),
		.instruction_memory_data(instruction_memory_data),
		.instruction_memory_address_out(instruction_memory_address_out),
		.instruction_memory_success(instruction_memory_success),
		.data_req(data_req),
		.data_memory_rdata(data_memory_rdata),
		.data_memory_success(data_memory_success),
		.data_memory_wr_mask_out(data_memory_wr_mask_out),
		.aux_address(aux_address),
		.aux_rd(aux_rd),
		.aux_rdata(aux_rdata),
		.aux_rdata_valid(aux_rdata_valid)
	);

	always #5 CLK = ~CLK;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
			$display("** FAIL **");
			$fatal(1, "Simulation stopped on a mismatch");
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic clear_requests();
		data_req.rd = 1'b0;
		data_req.wr = 1'b0;
		instruction_memory_read_req = 1'b0;
		aux_rd = 1'b0;
	endtask

	function automatic logic [BITS-1:0] apply_lanes(input logic [BITS-1:0] old_word,
			input logic [BITS-1:0] new_word, input byte_mask_t mask);
		logic [BITS-1:0] merged;
		merged = old_word;
		if (mask[0])
			merged[7:0] = new_word[7:0]; // Low byte lane
		if (mask[1])
			merged[15:8] = new_word[15:8];
		return merged;
	endfunction

	task automatic issue_data(input logic [ADDRESS_BITS-1:0] address,
			input logic [BITS-1:0] wdata, input byte_mask_t mask, input logic rd, input logic wr);
		data_req.address = address;
		data_req.wdata = wdata;
		data_req.wr_mask = mask;
		data_req.rd = rd;
		data_req.wr = wr;
	endtask

	// Called right after a request is driven, returns in the result cycle
	task automatic await_success(input logic instr);
		int cycles;
		logic ok;
		next_cycle();
		clear_requests();
		cycles = 1;
		ok = instr ? instruction_memory_success : data_memory_success;
		while (ok !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			next_cycle();
			cycles++;
			ok = instr ? instruction_memory_success : data_memory_success;
		end
		if (ok !== 1'b1) begin
			$display("ERROR: no success flag seen within %0d cycles at %0t", cycles, $time);
			$display("** FAIL **");
			$fatal(1, "Timed out waiting for a memory result");
		end
		check_value("result latency", 32'(cycles), 32'(RESULT_LATENCY));
	endtask

	task automatic data_write(input logic [ADDRESS_BITS-1:0] address,
			input logic [BITS-1:0] word, input byte_mask_t mask);
		issue_data(address, word, mask, 1'b0, 1'b1);
		await_success(1'b0);
		check_value("data_memory_wr_mask_out", 32'(data_memory_wr_mask_out), 32'(mask));
		ref_mem[address] = apply_lanes(ref_mem[address], word, mask); // Write was granted
	endtask

	task automatic data_read_check(input logic [ADDRESS_BITS-1:0] address);
		issue_data(address, '0, '0, 1'b1, 1'b0);
		await_success(1'b0);
		check_value("data_memory_rdata", 32'(data_memory_rdata), 32'(ref_mem[address]));
	endtask

	task automatic check_idle_outputs();
		check_value("instruction_memory_success", 32'(instruction_memory_success), 32'd0);
		check_value("data_memory_success", 32'(data_memory_success), 32'd0);
		check_value("aux_rdata_valid", 32'(aux_rdata_valid), 32'd0);
	endtask

	task automatic test_reset();
		RSTb = 1'b0;
		instruction_memory_address = '0;
		data_req = '0;
		aux_address = '0;
		clear_requests();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			next_cycle();
			check_idle_outputs(); // Registers are cleared from the first edge on
		end
		RSTb = 1'b1;
		next_cycle();
		check_idle_outputs();
		next_cycle();
		check_idle_outputs();
	endtask

	task automatic test_write_read();
		logic [ADDRESS_BITS-1:0] addrs [4];
		addrs = '{15'h0001, 15'h0100, 15'h2aaa, 15'h7fff};
		foreach (addrs[i])
			data_write(addrs[i], 16'($urandom), 2'b11);
		foreach (addrs[i])
			data_read_check(addrs[i]);
	endtask

	task automatic test_byte_lanes();
		data_write(15'h0123, 16'($urandom), 2'b11);
		data_write(15'h0123, 16'($urandom), 2'b01);
		data_read_check(15'h0123);
		data_write(15'h0123, 16'($urandom), 2'b10);
		data_read_check(15'h0123);
	endtask

	task automatic test_fetch_pipeline();
		logic [ADDRESS_BITS-1:0] addr;
		for (int i = 0; i < FETCHES; i++)
			data_write(ADDRESS_BITS'(15'h0400 + i), 16'($urandom), 2'b11);
		// One fetch per cycle, each result is checked two cycles after its request
		for (int c = 0; c <= FETCHES; c++) begin
			if (c < FETCHES) begin
				instruction_memory_address = ADDRESS_BITS'(15'h0400 + c);
				instruction_memory_read_req = 1'b1;
			end else begin
				instruction_memory_read_req = 1'b0;
			end
			next_cycle();
			if (c >= 1) begin
				addr = ADDRESS_BITS'(15'h0400 + c - 1);
				check_value("instruction_memory_success", 32'(instruction_memory_success), 32'd1);
				check_value("instruction_memory_data", 32'(instruction_memory_data),
					32'(ref_mem[addr]));
				check_value("instruction_memory_address_out",
					32'(instruction_memory_address_out), 32'(addr));
			end
		end
	endtask

	task automatic test_priority();
		issue_data(15'h0123, '0, '0, 1'b1, 1'b0);
		instruction_memory_address = 15'h0401;
		instruction_memory_read_req = 1'b1; // Same cycle as the data read
		next_cycle();
		clear_requests();
		next_cycle();
		check_value("data_memory_success", 32'(data_memory_success), 32'd1);
		check_value("instruction_memory_success", 32'(instruction_memory_success), 32'd0);
		check_value("data_memory_rdata", 32'(data_memory_rdata), 32'(ref_mem[15'h0123]));
		instruction_memory_read_req = 1'b1; // Reissue the dropped fetch
		await_success(1'b1);
		check_value("instruction_memory_data", 32'(instruction_memory_data),
			32'(ref_mem[15'h0401]));
		check_value("instruction_memory_address_out",
			32'(instruction_memory_address_out), 32'h0401);
	endtask

	task automatic aux_collision(input logic [ADDRESS_BITS-1:0] cpu_addr, input logic wr,
			input logic [ADDRESS_BITS-1:0] aux_addr);
		logic [BITS-1:0] word;
		word = 16'($urandom);
		issue_data(cpu_addr, word, 2'b11, ~wr, wr);
		next_cycle();
		clear_requests();
		aux_address = aux_addr; // Aux claims the RAM while the CPU request is in stage 1
		aux_rd = 1'b1;
		next_cycle();
		aux_rd = 1'b0;
		check_value("aux_rdata_valid", 32'(aux_rdata_valid), 32'd1);
		check_value("aux_rdata", 32'(aux_rdata), 32'(ref_mem[aux_addr]));
		check_value("data_memory_success", 32'(data_memory_success), 32'd0);
		data_read_check(cpu_addr); // A lost write leaves the old word
		if (wr) begin
			data_write(cpu_addr, word, 2'b11);
			data_read_check(cpu_addr);
		end
	endtask

	initial begin
		void'($urandom(32'hfcdc));
		test_reset();
		test_write_read();
		test_byte_lanes();
		test_fetch_pipeline();
		test_priority();
		aux_collision(15'h0100, 1'b1, 15'h2aaa);
		aux_collision(15'h7fff, 1'b0, 15'h0001);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: rtl/slurm16_memory_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Memory subsystem top level
// CPU memory interface feeding the arbiter, which drives the word RAM
////////////////////////////////////////////////////////////////////////////

module slurm16_memory_subsystem (
	input  logic CLK,
	input  logic RSTb,

	input  logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] instruction_memory_address,
	input  logic instruction_memory_read_req,
	output logic [slurm16_mem_pkg::BITS-1:0] instruction_memory_data,
	output logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] instruction_memory_address_out,
	output logic instruction_memory_success,

	input  slurm16_mem_pkg::cpu_data_req_t data_req,
	output logic [slurm16_mem_pkg::BITS-1:0] data_memory_rdata,
	output logic data_memory_success,
	output slurm16_mem_pkg::byte_mask_t data_memory_wr_mask_out,

	input  logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] aux_address,
	input  logic aux_rd,
	output logic [slurm16_mem_pkg::BITS-1:0] aux_rdata,
	output logic aux_rdata_valid
);

	import slurm16_mem_pkg::*;

	mem_req_t cpu_mem_req; // Stage 1 of the interface
	mem_req_t ram_req; // Whichever port won this cycle
	logic [BITS-1:0] cpu_rdata;
	logic [BITS-1:0] ram_rdata;
	logic memory_success;

	slurm16_cpu_memory_interface u_cpu_if (
		.CLK(CLK),
		.RSTb(RSTb),
		.instruction_memory_address(instruction_memory_address),
		.instruction_memory_read_req(instruction_memory_read_req),
		.instruction_memory_data(instruction_memory_data),
		.instruction_memory_address_out(instruction_memory_address_out),
		.instruction_memory_success(instruction_memory_success),
		.data_req(data_req),
		.data_memory_rdata(data_memory_rdata),
		.data_memory_success(data_memory_success),
		.data_memory_wr_mask_out(data_memory_wr_mask_out),
		.mem_req(cpu_mem_req),
		.rdata(cpu_rdata),
		.memory_success(memory_success)
	);

	slurm16_memory_arbiter u_arbiter (
		.CLK(CLK),
		.RSTb(RSTb),
		.cpu_req(cpu_mem_req),
		.cpu_rdata(cpu_rdata),
		.memory_success(memory_success),
		.aux_address(aux_address),
		.aux_rd(aux_rd),
		.aux_rdata(aux_rdata),
		.aux_rdata_valid(aux_rdata_valid),
		.ram_req(ram_req),
		.ram_rdata(ram_rdata)
	);

	slurm16_word_ram u_ram (
		.CLK(CLK),
		.req(ram_req),
		.rdata(ram_rdata)
	);

endmodule

// File: rtl/slurm16_cpu_memory_interface.sv
////////////////////////////////////////////////////////////////////////////
// CPU side memory interface
// Picks a data or instruction request, data first, into a two-stage
// pipeline, drives the arbiter from stage 1 and qualifies the arbiter's
// success flag per port from stage 2
////////////////////////////////////////////////////////////////////////////

module slurm16_cpu_memory_interface (
	input  logic CLK,
	input  logic RSTb,

	input  logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] instruction_memory_address,
	input  logic instruction_memory_read_req,
	output logic [slurm16_mem_pkg::BITS-1:0] instruction_memory_data,
	output logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] instruction_memory_address_out,
	output logic instruction_memory_success,

	input  slurm16_mem_pkg::cpu_data_req_t data_req,
	output logic [slurm16_mem_pkg::BITS-1:0] data_memory_rdata,
	output logic data_memory_success,
	output slurm16_mem_pkg::byte_mask_t data_memory_wr_mask_out,

	output slurm16_mem_pkg::mem_req_t mem_req,
	input  logic [slurm16_mem_pkg::BITS-1:0] rdata,
	input  logic memory_success
);

	import slurm16_mem_pkg::*;

	typedef struct packed {
		logic valid; // A request occupies this stage
		logic instr; // 1 = instruction fetch, 0 = data access
		logic rd; // 1 = read, 0 = write
	} stage_flags_t;

	stage_flags_t flags_s1;
	stage_flags_t flags_s1_next;
	stage_flags_t flags_s2;

	logic [ADDRESS_BITS-1:0] address_s1;
	logic [ADDRESS_BITS-1:0] address_s1_next;
	logic [ADDRESS_BITS-1:0] address_s2;
	logic [BITS-1:0] wdata_s1;
	logic [BITS-1:0] wdata_s1_next;
	byte_mask_t mask_s1;
	byte_mask_t mask_s1_next;
	byte_mask_t mask_s2;

	logic data_request;

	assign data_request = data_req.rd | data_req.wr;

	// Request selection. A fetch in the same cycle as a data access is dropped
	// and the fetcher sees no success for it
	always_comb begin
		address_s1_next = address_s1; // Address and data hold when idle
		wdata_s1_next = wdata_s1;
		flags_s1_next = '0;
		mask_s1_next = '0;

		if (data_request) begin
			address_s1_next = data_req.address;
			wdata_s1_next = data_req.wdata;
			flags_s1_next.valid = 1'b1;
			flags_s1_next.instr = 1'b0;
			flags_s1_next.rd = data_req.rd;
			mask_s1_next = data_req.wr_mask;
		end else if (instruction_memory_read_req) begin
			address_s1_next = instruction_memory_address;
			flags_s1_next.valid = 1'b1;
			flags_s1_next.instr = 1'b1;
			flags_s1_next.rd = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			flags_s1 <= '0;
			mask_s1 <= '0;
			flags_s2 <= '0;
		end else begin
			flags_s1 <= flags_s1_next;
			mask_s1 <= mask_s1_next;
			flags_s2 <= flags_s1;
		end
	end

	always_ff @(posedge CLK) begin
		address_s1 <= address_s1_next;
		wdata_s1 <= wdata_s1_next;
		address_s2 <= address_s1; // Passed back with the result
		mask_s2 <= mask_s1;
	end

	// Stage 1 drives the arbiter in the cycle after the request
	assign mem_req.address = address_s1;
	assign mem_req.wdata = wdata_s1;
	assign mem_req.wr_mask = mask_s1;
	assign mem_req.wr = flags_s1.valid & ~flags_s1.instr & ~flags_s1.rd;

	// Read word goes to both ports, the success flags say who owns it
	assign instruction_memory_data = rdata;
	assign data_memory_rdata = rdata;

	assign instruction_memory_address_out = address_s2;
	assign data_memory_wr_mask_out = mask_s2;

	assign instruction_memory_success = memory_success & flags_s2.valid & flags_s2.instr;
	assign data_memory_success = memory_success & flags_s2.valid & ~flags_s2.instr;

endmodule

// File: rtl/slurm16_memory_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Memory arbiter
// Shares the word RAM between the auxiliary read port and the CPU port,
// auxiliary first, and reports the previous cycle's owner to both sides
////////////////////////////////////////////////////////////////////////////

module slurm16_memory_arbiter (
	input  logic CLK,
	input  logic RSTb,

	input  slurm16_mem_pkg::mem_req_t cpu_req,
	output logic [slurm16_mem_pkg::BITS-1:0] cpu_rdata,
	output logic memory_success,

	input  logic [slurm16_mem_pkg::ADDRESS_BITS-1:0] aux_address,
	input  logic aux_rd,
	output logic [slurm16_mem_pkg::BITS-1:0] aux_rdata,
	output logic aux_rdata_valid,

	output slurm16_mem_pkg::mem_req_t ram_req,
	input  logic [slurm16_mem_pkg::BITS-1:0] ram_rdata
);

	import slurm16_mem_pkg::*;

	mem_req_t aux_req;
	logic cpu_grant_q;
	logic aux_grant_q;

	// Auxiliary port is read only
	assign aux_req.address = aux_address;
	assign aux_req.wdata = '0;
	assign aux_req.wr_mask = '0;
	assign aux_req.wr = 1'b0;

	// A CPU write that loses here is simply not performed
	assign ram_req = aux_rd ? aux_req : cpu_req;

	// The RAM answers one cycle later, so the grant is delayed to match
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cpu_grant_q <= 1'b0;
			aux_grant_q <= 1'b0;
		end else begin
			cpu_grant_q <= ~aux_rd; // CPU owns the RAM whenever aux is quiet
			aux_grant_q <= aux_rd;
		end
	end

	assign memory_success = cpu_grant_q;
	assign aux_rdata_valid = aux_grant_q;

	assign cpu_rdata = ram_rdata;
	assign aux_rdata = ram_rdata;

endmodule

// File: rtl/slurm16_word_ram.sv
////////////////////////////////////////////////////////////////////////////
// Single port word RAM
// Per-byte write enables and a registered, read-before-write output
////////////////////////////////////////////////////////////////////////////

module slurm16_word_ram (
	input  logic CLK,
	input  slurm16_mem_pkg::mem_req_t req,
	output logic [slurm16_mem_pkg::BITS-1:0] rdata
);

	import slurm16_mem_pkg::*;

	logic [BITS-1:0] mem [RAM_WORDS];

	// The read sees the old word when the same address is written
	always_ff @(posedge CLK) begin
		rdata <= mem[req.address];

		if (req.wr) begin
			for (int lane = 0; lane < BYTE_LANES; lane++) begin
				if (req.wr_mask[lane]) begin // Only enabled lanes change
					mem[req.address][lane*BYTE_BITS +: BYTE_BITS] <=
						req.wdata[lane*BYTE_BITS +: BYTE_BITS];
				end
			end
		end
	end

endmodule

// File: common/slurm16_mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the slurm16 memory side
// Word and address widths, byte lane layout and RAM depth
// Byte-lane write mask type
// Request structs for the RAM path and the CPU data port
////////////////////////////////////////////////////////////////////////////

package slurm16_mem_pkg;

	localparam int BITS = 16; // CPU data word width
	localparam int ADDRESS_BITS = 15; // Word address width
	localparam int BYTE_BITS = 8;
	localparam int BYTE_LANES = BITS / BYTE_BITS;
	localparam int RAM_WORDS = 1 << ADDRESS_BITS; // Every word address is backed

	// Bit 0 is the low byte, bit 1 the high byte, a 1 writes that lane
	typedef logic [BYTE_LANES-1:0] byte_mask_t;

	// Request as seen by the arbiter and the RAM
	typedef struct packed {
		logic [ADDRESS_BITS-1:0] address;
		logic [BITS-1:0] wdata;
		byte_mask_t wr_mask;
		logic wr; // Already qualified by request valid
	} mem_req_t;

	// Data port request coming from the CPU
	typedef struct packed {
		logic [ADDRESS_BITS-1:0] address;
		logic [BITS-1:0] wdata;
		byte_mask_t wr_mask;
		logic rd; // Read request
		logic wr; // Write request
	} cpu_data_req_t;

endpackage
